/* ppu_config.svh */
// PPU size configuration
// Widths and depths shared by the pixel pipeline and its package:
// beam coordinates, per-layer line memories and the colour palette

`ifndef PPU_CONFIG_SVH
`define PPU_CONFIG_SVH

// Beam coordinates
`define PPU_W_COORD      10

// Background line memories
`define PPU_LINE_DEPTH   64
`define PPU_W_LINE_ADDR  6

// Colour indices and palette (RGB555)
`define PPU_W_INDEX      4
`define PPU_PAL_DEPTH    16
`define PPU_W_COLOUR     15

`endif

/* ppu_pkg.sv */
// PPU shared types
// Config, host write port and the payloads that move between the
// background layers, blender, palette mapper and raster counter

`default_nettype none

`include "ppu_config.svh"

package ppu_pkg;

	typedef logic [`PPU_W_COLOUR-1:0] colour_t;

	// Write targets for the host strobe
	localparam logic [1:0] PPU_TGT_LINE0 = 2'd0;
	localparam logic [1:0] PPU_TGT_LINE1 = 2'd1;
	localparam logic [1:0] PPU_TGT_PAL   = 2'd2;

	// Static for the whole frame
	typedef struct packed {
		logic [`PPU_W_COORD-1:0]      width;
		logic [`PPU_W_COORD-1:0]      height;
		logic [1:0][`PPU_W_COORD-1:0] scroll_x;
		logic [1:0]                   layer_en;
		colour_t                      default_bg_colour;
	} ppu_cfg_t;

	typedef struct packed {
		logic                        en;
		logic [1:0]                  target;
		logic [`PPU_W_LINE_ADDR-1:0] addr;
		colour_t                     data;
	} ppu_wr_t;

	typedef struct packed {
		logic [`PPU_W_INDEX-1:0] index;
		logic                    transp;
	} layer_pix_t;

	// Index 0 means no layer is visible
	typedef struct packed {
		logic [`PPU_W_INDEX-1:0] index;
	} blend_pix_t;

	typedef struct packed {
		colour_t                 colour;
		logic [`PPU_W_COORD-1:0] x;
		logic [`PPU_W_COORD-1:0] y;
		logic                    row_start;
		logic                    frame_start;
	} out_pix_t;

endpackage

`default_nettype wire

/* ppu_pipe_reg.sv */
// Valid/ready register slice
// Holds a single item of any packed payload type. Ready looks through
// to the downstream ready, so a full slice still moves one item per cycle

`default_nettype none

module ppu_pipe_reg #(
	parameter type T = logic
) (
	input  wire  clk_ppu,
	input  wire  rst_n_ppu,

	input  wire  in_vld_i,
	output logic in_rdy_o,
	input  wire  T in_data_i,

	output logic out_vld_o,
	input  wire  out_rdy_i,
	output T     out_data_o
);

	logic vld_q;
	T     data_q;

	// Empty, or the held item leaves this cycle
	assign in_rdy_o = !vld_q || out_rdy_i;

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			vld_q <= 1'b0;
		end else if (in_rdy_o) begin
			vld_q <= in_vld_i;
		end
	end

	always_ff @(posedge clk_ppu) begin
		if (in_vld_i && in_rdy_o) begin
			data_q <= in_data_i;
		end
	end

	assign out_vld_o  = vld_q;
	assign out_data_o = data_q;

endmodule

`default_nettype wire

/* ppu_background.sv */
// Background layer
// Streams one scanline of colour indices out of a local line memory,
// offset by the layer's horizontal scroll. The host fills the memory
// through the shared write strobe

`default_nettype none

`include "ppu_config.svh"

module ppu_background import ppu_pkg::*; #(
	parameter int LAYER = 0
) (
	input  wire           clk_ppu,
	input  wire           rst_n_ppu,

	input  wire ppu_cfg_t cfg_i,
	input  wire ppu_wr_t  wr_i,
	input  wire           run_i,

	output logic          out_vld_o,
	input  wire           out_rdy_i,
	output layer_pix_t    out_pix_o
);

	logic [`PPU_W_INDEX-1:0]     line_mem [`PPU_LINE_DEPTH];
	logic [`PPU_W_COORD-1:0]     x_q;
	logic [`PPU_W_LINE_ADDR-1:0] rd_addr;
	layer_pix_t                  pix;
	logic                        slice_rdy;
	logic                        accept;

	// ----------------------------------------
	// Host writes

	always_ff @(posedge clk_ppu) begin
		if (wr_i.en && wr_i.target == 2'(LAYER)) begin
			line_mem[wr_i.addr] <= wr_i.data[`PPU_W_INDEX-1:0];
		end
	end

	// ----------------------------------------
	// Pixel generation

	// Address wraps mod line depth
	assign rd_addr    = x_q[`PPU_W_LINE_ADDR-1:0] +
		cfg_i.scroll_x[LAYER][`PPU_W_LINE_ADDR-1:0];
	assign pix.index  = line_mem[rd_addr];
	assign pix.transp = (pix.index == '0) || !cfg_i.layer_en[LAYER];

	assign accept = run_i && slice_rdy;

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			x_q <= '0;
		end else if (accept) begin
			if (x_q >= cfg_i.width - 1'b1) begin
				x_q <= '0;
			end else begin
				x_q <= x_q + 1'b1;
			end
		end
	end

	ppu_pipe_reg #(
		.T (layer_pix_t)
	) u_slice (
		.clk_ppu    (clk_ppu),
		.rst_n_ppu  (rst_n_ppu),
		.in_vld_i   (run_i),
		.in_rdy_o   (slice_rdy),
		.in_data_i  (pix),
		.out_vld_o  (out_vld_o),
		.out_rdy_i  (out_rdy_i),
		.out_data_o (out_pix_o)
	);

endmodule

`default_nettype wire

/* ppu_blender.sv */
// Two-layer blender
// Joins the layer streams so both are consumed together, then keeps
// layer 1 over layer 0. Where neither is opaque the output index is 0,
// which the palette mapper turns into the default background colour

`default_nettype none

module ppu_blender import ppu_pkg::*; (
	input  wire             l0_vld_i,
	output logic            l0_rdy_o,
	input  wire layer_pix_t l0_pix_i,

	input  wire             l1_vld_i,
	output logic            l1_rdy_o,
	input  wire layer_pix_t l1_pix_i,

	output logic            out_vld_o,
	input  wire             out_rdy_i,
	output blend_pix_t      out_pix_o
);

	// ----------------------------------------
	// Stream join

	// A layer is only taken when its partner is taken too
	assign out_vld_o = l0_vld_i && l1_vld_i;
	assign l0_rdy_o  = l1_vld_i && out_rdy_i;
	assign l1_rdy_o  = l0_vld_i && out_rdy_i;

	// ----------------------------------------
	// Priority select

	always_comb begin
		if (!l1_pix_i.transp) begin
			out_pix_o.index = l1_pix_i.index;
		end else if (!l0_pix_i.transp) begin
			out_pix_o.index = l0_pix_i.index;
		end else begin
			out_pix_o.index = '0;
		end
	end

endmodule

`default_nettype wire

/* ppu_palette_mapper.sv */
// Palette mapper
// Host-written palette of RGB555 colours. Each blended index is looked
// up and the colour registered in a one-deep slice. Index 0 selects the
// default background colour instead of palette entry 0

`default_nettype none

`include "ppu_config.svh"

module ppu_palette_mapper import ppu_pkg::*; (
	input  wire             clk_ppu,
	input  wire             rst_n_ppu,

	input  wire ppu_cfg_t   cfg_i,
	input  wire ppu_wr_t    wr_i,

	input  wire             in_vld_i,
	output logic            in_rdy_o,
	input  wire blend_pix_t in_pix_i,

	output logic            out_vld_o,
	input  wire             out_rdy_i,
	output colour_t         out_colour_o
);

	localparam int W_PAL_ADDR = $clog2(`PPU_PAL_DEPTH);

	colour_t palette [`PPU_PAL_DEPTH];
	colour_t lookup;

	// ----------------------------------------
	// Host writes

	// Upper address bits are ignored for the palette
	always_ff @(posedge clk_ppu) begin
		if (wr_i.en && wr_i.target == PPU_TGT_PAL) begin
			palette[wr_i.addr[W_PAL_ADDR-1:0]] <= wr_i.data;
		end
	end

	// ----------------------------------------
	// Lookup

	always_comb begin
		if (in_pix_i.index == '0) begin
			lookup = cfg_i.default_bg_colour;
		end else begin
			lookup = palette[in_pix_i.index];
		end
	end

	ppu_pipe_reg #(
		.T (colour_t)
	) u_slice (
		.clk_ppu    (clk_ppu),
		.rst_n_ppu  (rst_n_ppu),
		.in_vld_i   (in_vld_i),
		.in_rdy_o   (in_rdy_o),
		.in_data_i  (lookup),
		.out_vld_o  (out_vld_o),
		.out_rdy_i  (out_rdy_i),
		.out_data_o (out_colour_o)
	);

endmodule

`default_nettype wire

/* ppu_raster_counter.sv */
// Raster counter
// Tracks the beam position of the next delivered pixel and tags the
// passing colour with x, y and the row and frame start flags. The
// handshake goes straight through without adding a cycle

`default_nettype none

`include "ppu_config.svh"

module ppu_raster_counter import ppu_pkg::*; (
	input  wire           clk_ppu,
	input  wire           rst_n_ppu,

	input  wire ppu_cfg_t cfg_i,

	input  wire           in_vld_i,
	output logic          in_rdy_o,
	input  wire colour_t  in_colour_i,

	output logic          out_vld_o,
	input  wire           out_rdy_i,
	output out_pix_t      out_pix_o
);

	logic [`PPU_W_COORD-1:0] x_q;
	logic [`PPU_W_COORD-1:0] y_q;
	logic                    xfer;
	logic                    x_last;
	logic                    y_last;

	assign out_vld_o = in_vld_i;
	assign in_rdy_o  = out_rdy_i;
	assign xfer      = in_vld_i && out_rdy_i;

	assign x_last = x_q >= cfg_i.width - 1'b1;
	assign y_last = y_q >= cfg_i.height - 1'b1;

	// Beam only moves when a pixel is taken
	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			x_q <= '0;
			y_q <= '0;
		end else if (xfer) begin
			if (x_last) begin
				x_q <= '0;
				y_q <= y_last ? '0 : y_q + 1'b1;
			end else begin
				x_q <= x_q + 1'b1;
			end
		end
	end

	assign out_pix_o.colour      = in_colour_i;
	assign out_pix_o.x           = x_q;
	assign out_pix_o.y           = y_q;
	assign out_pix_o.row_start   = (x_q == '0);
	assign out_pix_o.frame_start = (x_q == '0) && (y_q == '0);

endmodule

`default_nettype wire

/* ppu_top.sv */
// PPU scanline pixel pipeline
// Two scrolled background layers feed a priority blender, then the
// palette mapper and the raster counter. Host writes fill the line
// memories and the palette; pixels leave over a valid/ready port

`default_nettype none

module ppu_top import ppu_pkg::*; (
	input  wire           clk_ppu,
	input  wire           rst_n_ppu,

	input  wire ppu_cfg_t cfg_i,
	input  wire           run_i,
	input  wire ppu_wr_t  wr_i,

	output logic          pix_vld_o,
	input  wire           pix_rdy_i,
	output out_pix_t      pix_o
);

	logic       bg0_vld;
	logic       bg0_rdy;
	layer_pix_t bg0_pix;
	logic       bg1_vld;
	logic       bg1_rdy;
	layer_pix_t bg1_pix;

	logic       blend_vld;
	logic       blend_rdy;
	blend_pix_t blend_pix;

	logic       pmap_vld;
	logic       pmap_rdy;
	colour_t    pmap_colour;

	// ----------------------------------------
	// Backgrounds

	ppu_background #(
		.LAYER (0)
	) u_bg0 (
		.clk_ppu   (clk_ppu),
		.rst_n_ppu (rst_n_ppu),
		.cfg_i     (cfg_i),
		.wr_i      (wr_i),
		.run_i     (run_i),
		.out_vld_o (bg0_vld),
		.out_rdy_i (bg0_rdy),
		.out_pix_o (bg0_pix)
	);

	ppu_background #(
		.LAYER (1)
	) u_bg1 (
		.clk_ppu   (clk_ppu),
		.rst_n_ppu (rst_n_ppu),
		.cfg_i     (cfg_i),
		.wr_i      (wr_i),
		.run_i     (run_i),
		.out_vld_o (bg1_vld),
		.out_rdy_i (bg1_rdy),
		.out_pix_o (bg1_pix)
	);

	// ----------------------------------------
	// Blend, palette lookup, beam tagging

	ppu_blender u_blender (
		.l0_vld_i  (bg0_vld),
		.l0_rdy_o  (bg0_rdy),
		.l0_pix_i  (bg0_pix),
		.l1_vld_i  (bg1_vld),
		.l1_rdy_o  (bg1_rdy),
		.l1_pix_i  (bg1_pix),
		.out_vld_o (blend_vld),
		.out_rdy_i (blend_rdy),
		.out_pix_o (blend_pix)
	);

	ppu_palette_mapper u_pmap (
		.clk_ppu      (clk_ppu),
		.rst_n_ppu    (rst_n_ppu),
		.cfg_i        (cfg_i),
		.wr_i         (wr_i),
		.in_vld_i     (blend_vld),
		.in_rdy_o     (blend_rdy),
		.in_pix_i     (blend_pix),
		.out_vld_o    (pmap_vld),
		.out_rdy_i    (pmap_rdy),
		.out_colour_o (pmap_colour)
	);

	ppu_raster_counter u_raster (
		.clk_ppu     (clk_ppu),
		.rst_n_ppu   (rst_n_ppu),
		.cfg_i       (cfg_i),
		.in_vld_i    (pmap_vld),
		.in_rdy_o    (pmap_rdy),
		.in_colour_i (pmap_colour),
		.out_vld_o   (pix_vld_o),
		.out_rdy_i   (pix_rdy_i),
		.out_pix_o   (pix_o)
	);

endmodule

`default_nettype wire

/* ppu_properties.sv */
// Output handshake properties for the PPU top level
// Bound into ppu_top. Checks that a stalled pixel holds still and
// that the output stays idle while reset is asserted

`default_nettype none

module ppu_properties import ppu_pkg::*; (
	input  wire           clk_ppu,
	input  wire           rst_n_ppu,
	input  wire           pix_vld_i,
	input  wire           pix_rdy_i,
	input  wire out_pix_t pix_i
);

	timeunit 1ns;
	timeprecision 100ps;

	// Read by the testbench top for the closing report
	int fail_cnt = 0;

	// A stalled pixel keeps valid and payload until taken
	hold_while_stalled: assert property (@(posedge clk_ppu) disable iff (!rst_n_ppu)
		pix_vld_i && !pix_rdy_i |=> pix_vld_i && $stable(pix_i))
	else begin
		$error("Output pixel changed or dropped valid while pix_rdy_i was low");
		fail_cnt++;
	end

	idle_in_reset: assert property (@(posedge clk_ppu) !rst_n_ppu |-> !pix_vld_i)
	else begin
		$error("pix_vld_o high while reset is asserted");
		fail_cnt++;
	end

endmodule

bind ppu_top ppu_properties u_props (
	.clk_ppu   (clk_ppu),
	.rst_n_ppu (rst_n_ppu),
	.pix_vld_i (pix_vld_o),
	.pix_rdy_i (pix_rdy_i),
	.pix_i     (pix_o)
);

`default_nettype wire

/* ppu_checker.sv */
// PPU output checker
// Snoops host writes into its own copies of the line memories and the
// palette, predicts every accepted output pixel from the layer, scroll,
// priority and raster rules, and checks the first-pixel latency

`default_nettype none

`include "ppu_config.svh"

module ppu_checker import ppu_pkg::*; (
	input  wire           clk_ppu,
	input  wire           rst_n_ppu,
	input  wire ppu_cfg_t cfg_i,
	input  wire ppu_wr_t  wr_i,
	input  wire           run_i,
	input  wire           pix_vld_i,
	input  wire           pix_rdy_i,
	input  wire out_pix_t pix_i,
	output int            pix_cnt_o,
	output int            err_cnt_o
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [`PPU_W_INDEX-1:0] line0 [`PPU_LINE_DEPTH];
	logic [`PPU_W_INDEX-1:0] line1 [`PPU_LINE_DEPTH];
	colour_t                 palette [`PPU_PAL_DEPTH];
	int                      pix_cnt = 0;
	int                      errs = 0;
	int                      run_cycles = 0;
	logic                    first_seen = 1'b0;

	assign pix_cnt_o = pix_cnt;
	assign err_cnt_o = errs;

	// Model of the host write port
	always @(posedge clk_ppu) begin
		if (wr_i.en) begin
			case (wr_i.target)
				PPU_TGT_LINE0: line0[wr_i.addr] = wr_i.data[`PPU_W_INDEX-1:0];
				PPU_TGT_LINE1: line1[wr_i.addr] = wr_i.data[`PPU_W_INDEX-1:0];
				PPU_TGT_PAL:   palette[wr_i.addr % `PPU_PAL_DEPTH] = wr_i.data;
				default: ;
			endcase
		end
	end

	// ----------------------------------------
	// Expected pixel n since reset

	function automatic out_pix_t expected_pixel(int n);
		out_pix_t                p;
		int                      lx;
		int                      ly;
		logic [`PPU_W_INDEX-1:0] idx0;
		logic [`PPU_W_INDEX-1:0] idx1;
		logic                    opq0;
		logic                    opq1;
		lx   = n % int'(cfg_i.width);
		ly   = (n / int'(cfg_i.width)) % int'(cfg_i.height);
		idx0 = line0[(lx + int'(cfg_i.scroll_x[0])) % `PPU_LINE_DEPTH];
		idx1 = line1[(lx + int'(cfg_i.scroll_x[1])) % `PPU_LINE_DEPTH];
		opq0 = (idx0 != 0) && cfg_i.layer_en[0];
		opq1 = (idx1 != 0) && cfg_i.layer_en[1];
		// Layer 1 wins, then layer 0, then the backdrop
		if (opq1) begin
			p.colour = palette[idx1];
		end else if (opq0) begin
			p.colour = palette[idx0];
		end else begin
			p.colour = cfg_i.default_bg_colour;
		end
		p.x           = `PPU_W_COORD'(lx);
		p.y           = `PPU_W_COORD'(ly);
		p.row_start   = (lx == 0);
		p.frame_start = (lx == 0) && (ly == 0);
		return p;
	endfunction

	// ----------------------------------------
	// Latency and pixel comparison

	always @(posedge clk_ppu) begin
		out_pix_t exp_pix;
		if (!rst_n_ppu) begin
			pix_cnt    = 0;
			run_cycles = 0;
			first_seen = 1'b0;
		end else begin
			if (pix_vld_i && !first_seen) begin
				first_seen = 1'b1;
				if (run_cycles != 2) begin
					errs++;
					$display("[ERROR] %0t ns: first pixel valid %0d cycles after run_i, expected 2",
						$time, run_cycles);
				end
			end else if (run_i && !first_seen) begin
				run_cycles++;
			end
			if (pix_vld_i && pix_rdy_i) begin
				exp_pix = expected_pixel(pix_cnt);
				if (pix_i !== exp_pix) begin
					errs++;
					$display("[ERROR] %0t ns: pixel %0d got colour %h at (%0d,%0d) rs/fs %b%b",
						$time, pix_cnt, pix_i.colour, pix_i.x, pix_i.y,
						pix_i.row_start, pix_i.frame_start);
					$display("        expected colour %h at (%0d,%0d) rs/fs %b%b",
						exp_pix.colour, exp_pix.x, exp_pix.y,
						exp_pix.row_start, exp_pix.frame_start);
				end
				pix_cnt++;
			end
		end
	end

endmodule

`default_nettype wire

/* tb_ppu.sv */
// PPU pixel pipeline testbench
// Runs several passes, each with reset, a random config, random line
// memory and palette contents, then two frames under random
// back-pressure. The checker compares every delivered pixel

`default_nettype none

`include "ppu_config.svh"

module tb_ppu import ppu_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_PASSES  = 3;
	localparam int PIX_TIMEOUT = 4000;
	localparam int DRAIN_LIMIT = 8;

	logic        clk_ppu = 1'b0;
	logic        rst_n_ppu;
	ppu_cfg_t    cfg;
	logic        run;
	ppu_wr_t     wr;
	logic        pix_vld;
	logic        pix_rdy;
	out_pix_t    pix;
	int          pix_cnt;
	int          data_errs;
	int          timeout_errs = 0;
	logic [31:0] rng_state = 32'd72085;

	always #4 clk_ppu = ~clk_ppu;

	ppu_top uut (
		.clk_ppu   (clk_ppu),
		.rst_n_ppu (rst_n_ppu),
		.cfg_i     (cfg),
		.run_i     (run),
		.wr_i      (wr),
		.pix_vld_o (pix_vld),
		.pix_rdy_i (pix_rdy),
		.pix_o     (pix)
	);

	ppu_checker u_checker (
		.clk_ppu   (clk_ppu),
		.rst_n_ppu (rst_n_ppu),
		.cfg_i     (cfg),
		.wr_i      (wr),
		.run_i     (run),
		.pix_vld_i (pix_vld),
		.pix_rdy_i (pix_rdy),
		.pix_i     (pix),
		.pix_cnt_o (pix_cnt),
		.err_cnt_o (data_errs)
	);

	// xorshift32
	function automatic logic [31:0] next_random();
		logic [31:0] s;
		s = rng_state;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		rng_state = s;
		return s;
	endfunction

	task automatic apply_reset();
		@(negedge clk_ppu);
		rst_n_ppu = 1'b0;
		repeat (3) @(negedge clk_ppu);
		rst_n_ppu = 1'b1;
	endtask

	// Pass 0 enables both layers, pass 1 only one, later passes random
	task automatic randomize_cfg(input int pass);
		logic [31:0] r;
		r = next_random();
		cfg.width       = `PPU_W_COORD'(16 + r[3:0]);
		cfg.height      = `PPU_W_COORD'(2 + r[5:4]);
		cfg.scroll_x[0] = r[15:6];
		cfg.scroll_x[1] = r[25:16];
		r = next_random();
		cfg.default_bg_colour = r[14:0];
		case (pass)
			0:       cfg.layer_en = 2'b11;
			1:       cfg.layer_en = r[16] ? 2'b01 : 2'b10;
			default: cfg.layer_en = r[18:17];
		endcase
	endtask

	task automatic host_write(input logic [1:0] target, input int addr, input colour_t data);
		@(negedge clk_ppu);
		wr.en     = 1'b1;
		wr.target = target;
		wr.addr   = `PPU_W_LINE_ADDR'(addr);
		wr.data   = data;
	endtask

	task automatic fill_memories();
		logic [31:0] r;
		colour_t     data;
		for (int i = 0; i < `PPU_LINE_DEPTH; i++) begin
			for (int l = 0; l < 2; l++) begin
				r = next_random();
				data = r[14:0];
				// Plenty of transparent entries
				if (r[17:16] == 2'b00) begin
					data[`PPU_W_INDEX-1:0] = '0;
				end
				host_write(l[1:0], i, data);
			end
		end
		for (int i = 0; i < `PPU_PAL_DEPTH; i++) begin
			r = next_random();
			host_write(PPU_TGT_PAL, i, r[14:0]);
		end
		@(negedge clk_ppu);
		wr = '0;
	endtask

	task automatic run_frames(input int pass);
		logic [31:0] r;
		int          target;
		int          cycles;
		target = 2 * int'(cfg.width) * int'(cfg.height);
		@(negedge clk_ppu);
		run     = 1'b1;
		pix_rdy = 1'b1;
		cycles  = 0;
		while (pix_cnt < target && cycles < PIX_TIMEOUT) begin
			@(negedge clk_ppu);
			cycles++;
			if (cycles >= 3) begin
				r = next_random();
				pix_rdy = r[0] | r[1];
			end
		end
		if (pix_cnt < target) begin
			timeout_errs++;
			$display("Timeout in pass %0d: only %0d of %0d pixels delivered",
				pass, pix_cnt, target);
		end
		// In-flight pixels must still come out
		run     = 1'b0;
		pix_rdy = 1'b1;
		cycles  = 0;
		while (pix_vld && cycles < DRAIN_LIMIT) begin
			@(negedge clk_ppu);
			cycles++;
		end
		if (pix_vld) begin
			timeout_errs++;
			$display("Timeout in pass %0d: output still valid after run_i dropped", pass);
		end
	endtask

	initial begin
		rst_n_ppu = 1'b1;
		run       = 1'b0;
		wr        = '0;
		cfg       = '0;
		pix_rdy   = 1'b0;
		for (int pass = 0; pass < NUM_PASSES; pass++) begin
			randomize_cfg(pass);
			apply_reset();
			fill_memories();
			run_frames(pass);
		end
		$display("Errors: %0d data, %0d assertion, %0d timeout",
			data_errs, uut.u_props.fail_cnt, timeout_errs);
		if (data_errs == 0 && uut.u_props.fail_cnt == 0 && timeout_errs == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
ppu_pkg.sv
ppu_pipe_reg.sv
ppu_background.sv
ppu_blender.sv
ppu_palette_mapper.sv
ppu_raster_counter.sv
ppu_top.sv
ppu_properties.sv
ppu_checker.sv
tb_ppu.sv

/* Bender.yml */
package:
  name: ppu_pixel_pipeline

sources:
  - include_dirs:
      - .
    files:
      - ppu_pkg.sv
      - ppu_pipe_reg.sv
      - ppu_background.sv
      - ppu_blender.sv
      - ppu_palette_mapper.sv
      - ppu_raster_counter.sv
      - ppu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - ppu_properties.sv
      - ppu_checker.sv
      - tb_ppu.sv
